//--- Bender.yml
package:
  name: routerLink

sources:
  - src/nocPkg.sv
  - src/flitFifo.sv
  - src/inputChannel.sv
  - src/packetTimer.sv
  - src/linkArbiter.sv
  - src/linkMux.sv
  - src/routerLink.sv
  - target: simulation
    files:
      - sim/clockGen.sv
      - sim/linkArbiter_asserts.sv
      - sim/routerLinkTb.sv

//--- flist.f
src/nocPkg.sv
src/flitFifo.sv
src/inputChannel.sv
src/packetTimer.sv
src/linkArbiter.sv
src/linkMux.sv
src/routerLink.sv
sim/clockGen.sv
sim/linkArbiter_asserts.sv
sim/routerLinkTb.sv

//--- sim/clockGen.sv
`timescale 1ns/1ps

module clockGen #(
  parameter int PeriodNs = 40,
  parameter int ResetCycles = 8
) (
  output logic clk,
  output logic rst
);

  initial
  begin
    clk = 1'b0;
    forever #(PeriodNs / 2) clk = ~clk;
  end

  initial
  begin
    rst = 1'b1;
    repeat (ResetCycles) @(posedge clk);
    @(negedge clk);
    rst = 1'b0; // released between edges.
  end

endmodule

//--- sim/linkArbiter_asserts.sv
`timescale 1ns/1ps

module linkArbiterAsserts import nocPkg::*; (
  input logic                   clk,
  input logic                   rst,
  input logic [NumChannels-1:0] req,
  input logic [NumChannels-1:0] timesUp,
  input grant_t                 grant
);

  int assertFails;
  logic holderReq;
  logic holderDone;

  initial assertFails = 0;

  assign holderReq = |(grant[NumChannels:1] & req);
  assign holderDone = |(grant[NumChannels:1] & timesUp);

  grantOneHot: assert property (@(posedge clk) disable iff (rst) $onehot(grant))
  else
  begin
    $error("arbiter grant is not one-hot");
    assertFails++;
  end

  grantIdleAfterReset: assert property (@(posedge clk) rst |=> (grant == GrantIdle))
  else
  begin
    $error("arbiter grant not idle after reset");
    assertFails++;
  end

  // holder still requesting with budget left keeps the link.
  grantHeld: assert property (@(posedge clk) disable iff (rst)
    (!grant[0] && holderReq && !holderDone) |=> (grant == $past(grant)))
  else
  begin
    $error("grant moved away from an active holder");
    assertFails++;
  end

endmodule

bind linkArbiter linkArbiterAsserts arbiterChecks (
  .clk(clk),
  .rst(rst),
  .req(req),
  .timesUp(timesUp),
  .grant(grant)
);

//--- sim/routerLinkTb.sv
`timescale 1ns/1ps

module routerLinkTb import nocPkg::*; ();

  localparam int FifoDepth = 8;
  localparam int MaxCycles = 4000; // roughly twice the whole run.
  localparam int RandomPackets = 120;

  logic clk;
  logic rst;
  flit_t inFlit [NumChannels];
  logic [NumChannels-1:0] inValid;
  logic [NumChannels-1:0] inFull;
  flit_t outFlit;
  chan_t outChan;
  logic outValid;

  flit_t expQ [NumChannels][$];
  flit_t stimQ [NumChannels][$];
  int startStep [NumChannels];
  chan_t linkLog [$];
  int cycleLog [$];
  chan_t startOrder [$];
  bit trackPackets;
  chan_t openChan;
  int openLeft;
  int passCount;
  int failCount;
  int cycleCount;
  flit_t monExp;

  clockGen #(.PeriodNs(40), .ResetCycles(8)) clocks (.clk(clk), .rst(rst));

  routerLink #(.FifoDepth(FifoDepth)) uut (
    .clk(clk),
    .rst(rst),
    .inFlit(inFlit),
    .inValid(inValid),
    .inFull(inFull),
    .outFlit(outFlit),
    .outChan(outChan),
    .outValid(outValid)
  );

  task automatic checkFlit(input string name, input flit_t actual, input flit_t expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s = kind %0d len %0d data %h, expected kind %0d len %0d data %h",
        $time, name, actual.kind, actual.length, actual.data,
        expected.kind, expected.length, expected.data);
      failCount++;
    end
    else
      passCount++;
  endtask

  task automatic checkChan(input string name, input chan_t actual, input chan_t expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s = %0d, expected %0d", $time, name, actual, expected);
      failCount++;
    end
    else
      passCount++;
  endtask

  task automatic checkLevel(input string name, input logic actual, input logic expected);
    if (actual !== expected)
    begin
      $display("FAILED at %0t: %s = %b, expected %b", $time, name, actual, expected);
      failCount++;
    end
    else
      passCount++;
  endtask

  // header, bodies, tail; random payload.
  task automatic makePacket(input chan_t c, input int size, input int lenField);
    flit_t f;
    for (int i = 0; i < size; i++)
    begin
      f.kind = (i == 0) ? KindHead : ((i == size - 1) ? KindTail : KindBody);
      f.length = (i == 0) ? LenWidth'(lenField) : '0;
      f.data = DataWidth'($urandom);
      stimQ[c].push_back(f);
    end
  endtask

  // one flit per channel and cycle; gaps only before a header.
  task automatic pumpStimulus(input bit packetGaps);
    int step;
    bit busy;
    bit gapNow;
    step = 0;
    busy = 1'b1;
    while (busy)
    begin
      @(negedge clk);
      busy = 1'b0;
      for (int c = 0; c < NumChannels; c++)
      begin
        inValid[c] = 1'b0;
        if (stimQ[c].size() > 0 && step >= startStep[c] && !inFull[c])
        begin
          gapNow = packetGaps && (stimQ[c][0].kind == KindHead) && ($urandom % 2 == 0);
          if (!gapNow)
          begin
            inFlit[c] = stimQ[c].pop_front();
            inValid[c] = 1'b1;
            expQ[c].push_back(inFlit[c]);
          end
        end
        if (stimQ[c].size() > 0)
          busy = 1'b1;
      end
      step++;
    end
  endtask

  task automatic idleInputs();
    @(negedge clk);
    inValid = '0;
  endtask

  task automatic waitDrained(input int limit);
    int waited;
    bit drained;
    waited = 0;
    drained = 1'b0;
    while (!drained && waited < limit)
    begin
      @(posedge clk);
      waited++;
      drained = 1'b1;
      for (int c = 0; c < NumChannels; c++)
        if (expQ[c].size() > 0)
          drained = 1'b0;
    end
    if (!drained)
    begin
      $display("flits still missing on the link after %0d cycles", limit);
      failCount++;
    end
    repeat (2) @(negedge clk);
  endtask

  task automatic waitFullClear(input chan_t c, input int limit);
    int waited;
    waited = 0;
    while (inFull[c] && waited < limit)
    begin
      @(negedge clk);
      waited++;
    end
    if (inFull[c])
    begin
      $display("channel %0d still full after %0d cycles", c, limit);
      failCount++;
    end
    else
      passCount++;
  endtask

  task automatic clearLogs(input bit track);
    linkLog.delete();
    cycleLog.delete();
    startOrder.delete();
    openLeft = 0;
    trackPackets = track;
    foreach (startStep[c])
      startStep[c] = 0;
  endtask

  // a packet must not be interleaved with another channel.
  task automatic trackPacket(input chan_t ch, input flit_t f);
    if (openLeft > 0)
    begin
      checkChan("outChan inside packet", ch, openChan);
      openLeft--;
    end
    else
    begin
      checkLevel("packet starts with header", f.kind == KindHead, 1'b1);
      startOrder.push_back(ch);
      openChan = ch;
      openLeft = f.length;
    end
  endtask

  task automatic finishTest(input string name, input int fails0);
    $display("%s: done, %0d errors", name, failCount - fails0);
  endtask

  always @(negedge clk)
  begin
    if (!rst && outValid)
    begin
      linkLog.push_back(outChan);
      cycleLog.push_back(cycleCount);
      if (outChan >= NumChannels)
      begin
        $display("outValid with channel index %0d out of range at %0t", outChan, $time);
        failCount++;
      end
      else if (expQ[outChan].size() == 0)
      begin
        $display("unexpected flit on channel %0d at %0t", outChan, $time);
        failCount++;
      end
      else
      begin
        monExp = expQ[outChan].pop_front();
        checkFlit("outFlit", outFlit, monExp);
        if (trackPackets)
          trackPacket(outChan, outFlit);
      end
    end
  end

  always @(posedge clk)
  begin
    cycleCount++;
    if (cycleCount >= MaxCycles)
    begin
      $display("timeout: run did not finish within %0d cycles", MaxCycles);
      $display("TESTS FAILED");
      $finish;
    end
  end

  task automatic resetState();
    int fails0;
    fails0 = failCount;
    clearLogs(1'b1);
    checkLevel("outValid", outValid, 1'b0);
    for (int c = 0; c < NumChannels; c++)
      checkLevel($sformatf("inFull[%0d]", c), inFull[c], 1'b0);
    repeat (10)
    begin
      @(negedge clk);
      checkLevel("outValid", outValid, 1'b0);
    end
    finishTest("reset state", fails0);
  endtask

  task automatic singlePacket();
    int fails0;
    fails0 = failCount;
    clearLogs(1'b1);
    makePacket(ChanW, 5, 4);
    pumpStimulus(1'b0);
    idleInputs();
    waitDrained(200);
    checkLevel("flit count", linkLog.size() == 5, 1'b1);
    foreach (linkLog[i])
      checkChan("outChan", linkLog[i], ChanW);
    if (cycleLog.size() == 5)
      checkLevel("flits back to back", (cycleLog[4] - cycleLog[0]) == 4, 1'b1);
    finishTest("single packet", fails0);
  endtask

  task automatic simultaneousStart();
    int fails0;
    int sizes [NumChannels];
    fails0 = failCount;
    sizes = '{3, 5, 2, 4, 6};
    clearLogs(1'b1);
    for (int c = 0; c < NumChannels; c++)
      makePacket(chan_t'(c), sizes[c], sizes[c] - 1);
    pumpStimulus(1'b0); // all headers land in the same cycle.
    idleInputs();
    waitDrained(200);
    checkLevel("packet count", startOrder.size() == NumChannels, 1'b1);
    foreach (startOrder[i])
      checkChan("packet order", startOrder[i], chan_t'(i));
    finishTest("simultaneous start", fails0);
  endtask

  task automatic timeoutRelease();
    int fails0;
    fails0 = failCount;
    clearLogs(1'b0);
    makePacket(ChanE, 5, 1); // header budget is two flits.
    makePacket(ChanW, 3, 2);
    pumpStimulus(1'b0);
    idleInputs();
    waitDrained(200);
    checkLevel("flit count", linkLog.size() == 8, 1'b1);
    if (linkLog.size() == 8)
    begin
      for (int i = 0; i < 8; i++)
        checkChan("outChan", linkLog[i], (i >= 2 && i < 5) ? ChanW : ChanE);
      // remainder starts on a body flit, so the two-flit budget stays.
      checkLevel("remainder keeps budget", (cycleLog[6] - cycleLog[5]) == 1, 1'b1);
    end
    finishTest("timeout release", fails0);
  endtask

  task automatic fullFlag();
    int fails0;
    flit_t rest [$];
    fails0 = failCount;
    clearLogs(1'b1);
    makePacket(ChanL, 21, 20);
    makePacket(ChanN, FifoDepth, FifoDepth - 1);
    repeat (10)
      rest.push_front(stimQ[ChanL].pop_back());
    startStep[ChanN] = 2; // N starts once L holds the link.
    pumpStimulus(1'b0);
    checkLevel("inFull[N]", inFull[ChanN], 1'b1);
    checkLevel("inFull[L]", inFull[ChanL], 1'b0);
    stimQ[ChanL] = rest;
    startStep[ChanN] = 0;
    pumpStimulus(1'b0);
    idleInputs();
    waitFullClear(ChanN, 100);
    waitDrained(200);
    checkLevel("packet count", startOrder.size() == 2, 1'b1);
    if (startOrder.size() == 2)
      checkChan("second packet", startOrder[1], ChanN);
    finishTest("full flag", fails0);
  endtask

  task automatic randomTraffic();
    int fails0;
    int c;
    int size;
    fails0 = failCount;
    clearLogs(1'b1);
    for (int p = 0; p < RandomPackets; p++)
    begin
      c = $urandom % NumChannels;
      size = 1 + $urandom % 6;
      makePacket(chan_t'(c), size, size - 1);
    end
    pumpStimulus(1'b1);
    idleInputs();
    waitDrained(1000);
    checkLevel("packet count", startOrder.size() == RandomPackets, 1'b1);
    finishTest("random traffic", fails0);
  endtask

  initial
  begin
    passCount = 0;
    failCount = 0;
    cycleCount = 0;
    openLeft = 0;
    trackPackets = 1'b0;
    inValid = '0;
    foreach (inFlit[c])
      inFlit[c] = '0;
    void'($urandom(32'h5e7d_d331));
    @(negedge clk);
    while (rst)
      @(negedge clk);
    resetState();
    singlePacket();
    simultaneousStart();
    timeoutRelease();
    fullFlag();
    randomTraffic();
    failCount += uut.arbiter.arbiterChecks.assertFails;
    $display("checks passed %0d, failed %0d", passCount, failCount);
    if (failCount == 0)
      $display("TESTS PASSED");
    else
      $display("TESTS FAILED");
    $finish;
  end

endmodule

//--- src/flitFifo.sv
`timescale 1ns/1ps

module flitFifo #(
  parameter int FifoDepth = 8,
  parameter type payload_t = logic [7:0]
) (
  input  logic     clk,
  input  logic     rst,
  input  payload_t wrData,
  input  logic     wrEn,
  input  logic     rdEn,
  output payload_t rdData,
  output logic     empty,
  output logic     full
);

  localparam int PtrWidth = (FifoDepth > 1) ? $clog2(FifoDepth) : 1;
  localparam int CountWidth = $clog2(FifoDepth + 1);

  payload_t mem [FifoDepth];
  logic [PtrWidth-1:0] wrPtr;
  logic [PtrWidth-1:0] rdPtr;
  logic [CountWidth-1:0] count;
  logic doWrite;
  logic doRead;

  function automatic logic [PtrWidth-1:0] nextPtr(input logic [PtrWidth-1:0] ptr);
    if (ptr == PtrWidth'(FifoDepth - 1))
      return '0;
    return ptr + 1'b1;
  endfunction

  assign empty = (count == '0);
  assign full = (count == CountWidth'(FifoDepth));
  assign doWrite = wrEn && !full;  // write on full dropped.
  assign doRead = rdEn && !empty;
  assign rdData = mem[rdPtr];      // head entry.

  always_ff @(posedge clk)
  begin
    if (doWrite)
      mem[wrPtr] <= wrData;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end
    else
    begin
      if (doWrite)
        wrPtr <= nextPtr(wrPtr);
      if (doRead)
        rdPtr <= nextPtr(rdPtr);
      case ({doWrite, doRead})
        2'b10: count <= count + 1'b1;
        2'b01: count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/inputChannel.sv
`timescale 1ns/1ps

module inputChannel import nocPkg::*; #(
  parameter int FifoDepth = 8
) (
  input  logic  clk,
  input  logic  rst,
  input  flit_t inFlit,
  input  logic  inValid,
  input  logic  pop,
  output flit_t headFlit,
  output logic  req,
  output logic  full
);

  logic empty;

  // flit buffer for this channel.
  flitFifo #(
    .FifoDepth(FifoDepth),
    .payload_t(flit_t)
  ) buffer (
    .clk(clk),
    .rst(rst),
    .wrData(inFlit),
    .wrEn(inValid),
    .rdEn(pop),
    .rdData(headFlit),
    .empty(empty),
    .full(full)
  );

  assign req = !empty; // request while anything is buffered.

endmodule

//--- src/linkArbiter.sv
`timescale 1ns/1ps

module linkArbiter import nocPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  logic [NumChannels-1:0] req,
  input  flit_t                  headFlit [NumChannels],
  output grant_t                 grant
);

  grant_t nextGrant;
  chan_t holder;
  logic [NumChannels-1:0] runTimer;
  logic [NumChannels-1:0] timesUp;

  for (genvar c = 0; c < NumChannels; c++)
  begin : genTimer
    flitKind_t headKind;

    // an empty buffer shows a stale head.
    assign headKind = req[c] ? headFlit[c].kind : KindNone;

    packetTimer timer (
      .clk(clk),
      .rst(rst),
      .kind(headKind),
      .length(headFlit[c].length),
      .runTimer(runTimer[c]),
      .timesUp(timesUp[c])
    );
  end

  always_comb
  begin
    holder = '0;
    for (int c = 0; c < NumChannels; c++)
    begin
      if (grant[c + 1])
        holder = chan_t'(c);
    end
  end

  always_comb
  begin
    int idx;

    nextGrant = GrantIdle;
    runTimer = '0;
    idx = 0;
    if (!$onehot(grant))
      nextGrant = GrantIdle;
    else if (grant[0])
    begin
      // fixed priority, L first.
      for (int c = NumChannels - 1; c >= 0; c--)
      begin
        if (req[c])
          nextGrant = grant_t'(1) << (c + 1);
      end
    end
    else if (req[holder] && !timesUp[holder])
    begin
      runTimer[holder] = 1'b1;
      nextGrant = grant;
    end
    else
    begin
      // nearest requester after the holder wins.
      for (int i = NumChannels - 1; i >= 1; i--)
      begin
        idx = (int'(holder) + i) % NumChannels;
        if (req[idx])
          nextGrant = grant_t'(1) << (idx + 1);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      grant <= GrantIdle;
    else
      grant <= nextGrant;
  end

endmodule

//--- src/linkMux.sv
`timescale 1ns/1ps

module linkMux import nocPkg::*; (
  input  logic                   clk,
  input  logic                   rst,
  input  grant_t                 grant,
  input  logic [NumChannels-1:0] req,
  input  flit_t                  headFlit [NumChannels],
  output logic [NumChannels-1:0] pop,
  output flit_t                  outFlit,
  output chan_t                  outChan,
  output logic                   outValid
);

  flit_t selFlit;
  chan_t selChan;

  always_comb
  begin
    selFlit = headFlit[0];
    selChan = '0;
    for (int c = 0; c < NumChannels; c++)
    begin
      pop[c] = grant[c + 1] && req[c]; // holder popped while it requests.
      if (grant[c + 1])
      begin
        selFlit = headFlit[c];
        selChan = chan_t'(c);
      end
    end
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      outValid <= 1'b0;
    else
      outValid <= |pop;
  end

  always_ff @(posedge clk)
  begin
    outFlit <= selFlit;
    outChan <= selChan;
  end

endmodule

//--- src/nocPkg.sv
package nocPkg;

  localparam int NumChannels = 5;
  localparam int LenWidth = 12;
  localparam int DataWidth = 16;

  typedef enum logic [2:0] {
    KindNone = 3'd0, // no flit at the head.
    KindHead = 3'd1,
    KindBody = 3'd2,
    KindTail = 3'd3
  } flitKind_t;

  // 31-bit flit.
  typedef struct packed {
    flitKind_t kind;
    logic [LenWidth-1:0] length; // flits in packet minus one, header only.
    logic [DataWidth-1:0] data;
  } flit_t;

  typedef logic [2:0] chan_t;

  localparam chan_t ChanL = 3'd0;
  localparam chan_t ChanN = 3'd1;
  localparam chan_t ChanE = 3'd2;
  localparam chan_t ChanW = 3'd3;
  localparam chan_t ChanS = 3'd4;

  // bit 0 idle, bit c+1 channel c.
  typedef logic [NumChannels:0] grant_t;

  localparam grant_t GrantIdle = grant_t'(1);

endpackage

//--- src/packetTimer.sv
`timescale 1ns/1ps

module packetTimer import nocPkg::*; (
  input  logic                clk,
  input  logic                rst,
  input  flitKind_t           kind,
  input  logic [LenWidth-1:0] length,
  input  logic                runTimer,
  output logic                timesUp
);

  logic [LenWidth-1:0] limit;
  logic [LenWidth-1:0] count;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      limit <= '0;
      count <= '0;
    end
    else
    begin
      if (kind == KindHead)
        limit <= length; // budget from the header at the head.
      if (runTimer)
        count <= count + 1'b1;
      else
        count <= '0;
    end
  end

  // high in the last granted cycle.
  assign timesUp = (count == limit);

endmodule

//--- src/routerLink.sv
`timescale 1ns/1ps

module routerLink import nocPkg::*; #(
  parameter int FifoDepth = 8
) (
  input  logic                   clk,
  input  logic                   rst,
  input  flit_t                  inFlit [NumChannels],
  input  logic [NumChannels-1:0] inValid,
  output logic [NumChannels-1:0] inFull,
  output flit_t                  outFlit,
  output chan_t                  outChan,
  output logic                   outValid
);

  flit_t headFlit [NumChannels];
  logic [NumChannels-1:0] req;
  logic [NumChannels-1:0] pop;
  grant_t grant;

  // L, N, E, W, S.
  for (genvar c = 0; c < NumChannels; c++)
  begin : genChannel
    inputChannel #(
      .FifoDepth(FifoDepth)
    ) channel (
      .clk(clk),
      .rst(rst),
      .inFlit(inFlit[c]),
      .inValid(inValid[c]),
      .pop(pop[c]),
      .headFlit(headFlit[c]),
      .req(req[c]),
      .full(inFull[c])
    );
  end

  linkArbiter arbiter (
    .clk(clk),
    .rst(rst),
    .req(req),
    .headFlit(headFlit),
    .grant(grant)
  );

  linkMux mux (
    .clk(clk),
    .rst(rst),
    .grant(grant),
    .req(req),
    .headFlit(headFlit),
    .pop(pop),
    .outFlit(outFlit),
    .outChan(outChan),
    .outValid(outValid)
  );

endmodule
